// ==== verilog/num_fmt_pkg.sv ====
package num_fmt_pkg;

    // ====================================================================
    // Field geometry
    // ====================================================================

    // Width of the unsigned value that gets printed
    localparam int VALUE_BITS = 64;

    // A 64-bit value needs at most 16 hex digits
    localparam int HEX_DIGITS = 16;

    // The largest 64-bit value has 20 decimal digits
    localparam int DEC_DIGITS = 20;

    // Hex digit count used when the caller asks for zero digits
    localparam int DEFAULT_HEX_DIGITS = 8;

    // Digits between two separators
    localparam int HEX_GROUP = 4;
    localparam int DEC_GROUP = 3;

    // ====================================================================
    // Character codes and radix codes
    // ====================================================================

    localparam logic [7:0] CHAR_UNDERSCORE = 8'h5f;
    localparam logic [7:0] CHAR_COMMA      = 8'h2c;
    localparam logic [7:0] CHAR_SPACE      = 8'h20;
    localparam logic [7:0] CHAR_ZERO       = 8'h30;

    // One-bit radix select on the request port
    localparam logic RADIX_HEX = 1'b0;
    localparam logic RADIX_DEC = 1'b1;

    // Maps one nibble to its lower-case ASCII digit
    function automatic logic [7:0] nibble_to_ascii(input logic [3:0] nibble);
        if (nibble < 4'd10) begin
            return CHAR_ZERO + {4'h0, nibble};
        end
        // Values 10 to 15 become 'a' to 'f'
        return 8'h61 + {4'h0, nibble - 4'd10};
    endfunction

endpackage

// ==== verilog/bcd_double_dabble.sv ====
module bcd_double_dabble import num_fmt_pkg::*; (
    input  logic                    CLK,
    input  logic                    RESETN,
    input  logic [VALUE_BITS-1:0]   binary,
    input  logic                    bcd_start,
    output logic [DEC_DIGITS*4-1:0] bcd,
    output logic                    bcd_done
);

    // Counter widths for the 64 input bits and the 20 BCD digits
    localparam int LOOP_W = $clog2(VALUE_BITS);
    localparam int DIG_W  = $clog2(DEC_DIGITS);

    // Converter FSM states
    localparam logic [2:0] S_IDLE        = 3'd0;
    localparam logic [2:0] S_SHIFT       = 3'd1;
    localparam logic [2:0] S_CHECK_SHIFT = 3'd2;
    localparam logic [2:0] S_ADD         = 3'd3;
    localparam logic [2:0] S_CHECK_DIGIT = 3'd4;

    logic [2:0]            state;

    // Binary value still to be shifted in, MSB first
    logic [VALUE_BITS-1:0] bin_q;

    // Number of shifts done so far, minus one
    logic [LOOP_W-1:0]     loop_cnt;

    // BCD digit under test in the add pass
    logic [DIG_W-1:0]      digit_idx;
    logic [3:0]            cur_digit;

    assign cur_digit = bcd[{digit_idx, 2'b00} +: 4];

    // ====================================================================
    // Shift and add-three sequencer
    // ====================================================================

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (bcd_start) begin
                        bin_q     <= binary;
                        bcd       <= '0;
                        loop_cnt  <= '0;
                        digit_idx <= '0;
                        state     <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    // Move the top binary bit into the bottom of the BCD word
                    bcd   <= {bcd[DEC_DIGITS*4-2:0], bin_q[VALUE_BITS-1]};
                    bin_q <= bin_q << 1;
                    state <= S_CHECK_SHIFT;
                end
                S_CHECK_SHIFT: begin
                    // No correction follows the final shift
                    if (loop_cnt == LOOP_W'(VALUE_BITS - 1)) begin
                        state <= S_IDLE;
                    end else begin
                        loop_cnt <= loop_cnt + 1'b1;
                        state    <= S_ADD;
                    end
                end
                S_ADD: begin
                    // A digit of five or more would overflow when doubled
                    if (cur_digit > 4'd4) begin
                        bcd[{digit_idx, 2'b00} +: 4] <= cur_digit + 4'd3;
                    end
                    state <= S_CHECK_DIGIT;
                end
                S_CHECK_DIGIT: begin
                    if (digit_idx == DIG_W'(DEC_DIGITS - 1)) begin
                        digit_idx <= '0;
                        state     <= S_SHIFT;
                    end else begin
                        digit_idx <= digit_idx + 1'b1;
                        state     <= S_ADD;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // The BCD word is valid once the FSM has returned to idle
    assign bcd_done = (state == S_IDLE) && !bcd_start;

endmodule

// ==== verilog/digit_emitter.sv ====
module digit_emitter import num_fmt_pkg::*; #(
    parameter int OUT_CHARS = 26
) (
    input  logic                    CLK,
    input  logic                    RESETN,
    input  logic                    emit_load,
    input  logic [DEC_DIGITS*4-1:0] emit_digits,
    input  logic                    emit_radix,
    input  logic [4:0]              emit_count,
    input  logic                    nosep,
    input  logic [4:0]              field_width,
    output logic [OUT_CHARS*8-1:0]  result,
    output logic                    emit_busy
);

    // Position index width, position 0 is the leftmost character
    localparam int IDX_W = (OUT_CHARS > 1) ? $clog2(OUT_CHARS) : 1;
    localparam logic [IDX_W-1:0] LAST_POS = IDX_W'(OUT_CHARS - 1);

    // Emitter FSM states
    localparam logic [1:0] E_IDLE  = 2'd0;
    localparam logic [1:0] E_WRITE = 2'd1;
    localparam logic [1:0] E_BLANK = 2'd2;

    logic [1:0]              state;

    // Character field, one byte per position
    logic [7:0]              chars [OUT_CHARS];

    // Digit store and format options taken at load
    logic [DEC_DIGITS*4-1:0] digits_q;
    logic                    radix_q;
    logic [4:0]              count_q;
    logic                    nosep_q;
    logic [4:0]              width_q;

    // Source digit counts up from the least significant nibble
    logic [4:0]              src_idx;
    // Destination walks left in the write pass and right in the blank pass
    logic [IDX_W-1:0]        dst_idx;
    // Digits written since the last separator, minus one
    logic [1:0]              grp_cnt;

    logic [3:0]              cur_nibble;
    logic [1:0]              grp_last;
    logic [7:0]              sep_char;
    logic                    last_digit;
    logic                    sep_now;
    logic                    write_done;
    logic [7:0]              cur_char;
    logic                    in_field;
    logic [7:0]              blank_char;

    // ====================================================================
    // Radix-dependent choices
    // ====================================================================

    // Decimal groups by three with commas, hex by four with underscores
    assign grp_last = (radix_q == RADIX_DEC) ? 2'(DEC_GROUP - 1) : 2'(HEX_GROUP - 1);
    assign sep_char = (radix_q == RADIX_DEC) ? CHAR_COMMA : CHAR_UNDERSCORE;

    assign cur_nibble = digits_q[{src_idx, 2'b00} +: 4];

    // Stop after the requested digits or when the field runs out
    assign last_digit = (src_idx == count_q - 5'd1) || (dst_idx == '0);

    // A separator only goes in when another digit is still to come
    assign sep_now = !nosep_q && (grp_cnt == grp_last) && !last_digit;

    // A separator landing on position zero leaves no room for more digits
    assign write_done = last_digit || (sep_now && (dst_idx == IDX_W'(1)));

    // Blank-pass helpers
    assign cur_char = chars[dst_idx];

    // True when the position lies inside the rightmost field_width characters
    assign in_field   = (int'(dst_idx) + int'(width_q)) >= OUT_CHARS;
    assign blank_char = in_field ? CHAR_SPACE : 8'h00;

    // ====================================================================
    // Write and blank passes
    // ====================================================================

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            state <= E_IDLE;
            // Field reads as all zero bytes until the first request
            for (int i = 0; i < OUT_CHARS; i++) begin
                chars[i] <= 8'h00;
            end
        end else begin
            case (state)
                E_IDLE: begin
                    if (emit_load) begin
                        for (int i = 0; i < OUT_CHARS; i++) begin
                            chars[i] <= 8'h00;
                        end
                        digits_q <= emit_digits;
                        radix_q  <= emit_radix;
                        count_q  <= emit_count;
                        nosep_q  <= nosep;
                        width_q  <= field_width;
                        src_idx  <= 5'd0;
                        dst_idx  <= LAST_POS;
                        grp_cnt  <= 2'd0;
                        state    <= E_WRITE;
                    end
                end
                E_WRITE: begin
                    // One digit per cycle, filled in from the right
                    chars[dst_idx] <= nibble_to_ascii(cur_nibble);
                    src_idx        <= src_idx + 5'd1;
                    if (sep_now) begin
                        chars[dst_idx - IDX_W'(1)] <= sep_char;
                    end
                    if (write_done) begin
                        // Only decimal gets its leading zeros blanked
                        if (radix_q == RADIX_DEC) begin
                            dst_idx <= '0;
                            state   <= E_BLANK;
                        end else begin
                            state <= E_IDLE;
                        end
                    end else if (sep_now) begin
                        // Skip over the separator just placed
                        dst_idx <= dst_idx - IDX_W'(2);
                        grp_cnt <= 2'd0;
                    end else begin
                        dst_idx <= dst_idx - IDX_W'(1);
                        grp_cnt <= grp_cnt + 2'd1;
                    end
                end
                E_BLANK: begin
                    // The rightmost character is never blanked so zero prints as "0"
                    if (dst_idx == LAST_POS) begin
                        state <= E_IDLE;
                    end else if (cur_char == CHAR_ZERO || cur_char == CHAR_COMMA) begin
                        chars[dst_idx] <= blank_char;
                    end else if (cur_char != 8'h00) begin
                        // First significant digit ends the scan
                        state <= E_IDLE;
                    end
                    dst_idx <= dst_idx + IDX_W'(1);
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    assign emit_busy = (state != E_IDLE);

    // Position zero ends up in the most significant byte of result
    always_comb begin
        for (int i = 0; i < OUT_CHARS; i++) begin
            result[i*8 +: 8] = chars[OUT_CHARS-1-i];
        end
    end

endmodule

// ==== verilog/num_formatter.sv ====
module num_formatter import num_fmt_pkg::*; #(
    parameter int OUT_CHARS = 26
) (
    input  logic                   CLK,
    input  logic                   RESETN,
    input  logic [VALUE_BITS-1:0]  value,
    input  logic                   radix,
    input  logic [4:0]             hex_digits,
    input  logic [4:0]             field_width,
    input  logic                   nosep,
    input  logic                   start,
    output logic [OUT_CHARS*8-1:0] result,
    output logic                   idle
);

    // Request FSM states
    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_WAIT_BCD  = 2'd1;
    localparam logic [1:0] ST_WAIT_EMIT = 2'd2;

    logic [1:0]              state;
    logic                    accept;

    // Request fields captured when a start is accepted
    logic [VALUE_BITS-1:0]   value_q;
    logic                    radix_q;
    logic                    nosep_q;
    logic [4:0]              width_q;
    logic [4:0]              count_q;
    logic [4:0]              hex_count;

    // Converter and emitter handshakes
    logic                    bcd_start;
    logic [DEC_DIGITS*4-1:0] bcd;
    logic                    bcd_done;
    logic                    emit_load;
    logic [DEC_DIGITS*4-1:0] emit_digits;
    logic                    emit_busy;

    // A request is taken only while the FSM sits in idle
    assign accept = (state == ST_IDLE) && start;

    // Zero asks for the default count and anything above 16 is capped
    always_comb begin
        if (hex_digits == 5'd0) begin
            hex_count = 5'(DEFAULT_HEX_DIGITS);
        end else if (hex_digits > 5'(HEX_DIGITS)) begin
            hex_count = 5'(HEX_DIGITS);
        end else begin
            hex_count = hex_digits;
        end
    end

    // Request fields only change on an accepted start
    always_ff @(posedge CLK) begin
        if (accept) begin
            value_q <= value;
            radix_q <= radix;
            nosep_q <= nosep;
            width_q <= field_width;
            count_q <= (radix == RADIX_DEC) ? 5'(DEC_DIGITS) : hex_count;
        end
    end

    // ====================================================================
    // Request sequencing
    // ====================================================================

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            state     <= ST_IDLE;
            bcd_start <= 1'b0;
            emit_load <= 1'b0;
        end else begin
            // Both starts are single-cycle pulses
            bcd_start <= 1'b0;
            emit_load <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        // Decimal goes through the BCD converter first
                        if (radix == RADIX_DEC) begin
                            bcd_start <= 1'b1;
                            state     <= ST_WAIT_BCD;
                        end else begin
                            emit_load <= 1'b1;
                            state     <= ST_WAIT_EMIT;
                        end
                    end
                end
                ST_WAIT_BCD: begin
                    if (bcd_done) begin
                        emit_load <= 1'b1;
                        state     <= ST_WAIT_EMIT;
                    end
                end
                ST_WAIT_EMIT: begin
                    // Busy only rises the cycle after the load pulse
                    if (!emit_load && !emit_busy) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Hex digits are the raw value padded up to the BCD width
    assign emit_digits = (radix_q == RADIX_DEC) ? bcd
                       : {{(DEC_DIGITS*4-VALUE_BITS){1'b0}}, value_q};

    assign idle = (state == ST_IDLE) && !start;

    bcd_double_dabble u_bcd (
        .CLK       (CLK),
        .RESETN    (RESETN),
        .binary    (value_q),
        .bcd_start (bcd_start),
        .bcd       (bcd),
        .bcd_done  (bcd_done)
    );

    digit_emitter #(
        .OUT_CHARS (OUT_CHARS)
    ) u_emit (
        .CLK         (CLK),
        .RESETN      (RESETN),
        .emit_load   (emit_load),
        .emit_digits (emit_digits),
        .emit_radix  (radix_q),
        .emit_count  (count_q),
        .nosep       (nosep_q),
        .field_width (width_q),
        .result      (result),
        .emit_busy   (emit_busy)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic CLK,
    output logic RESETN
);

    timeunit 1ns;
    timeprecision 1ps;

    // Reset stays low for this many rising edges
    localparam int RESET_CYCLES = 10;

    // Free-running clock with a 4 ns period
    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Reset is released on a falling edge like every other DUT input
    initial begin
        RESETN = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RESETN = 1'b1;
    end

endmodule

// ==== testbench/num_formatter_assertions.sv ====
module num_formatter_assertions #(
    parameter int OUT_CHARS = 26
) (
    input logic                   CLK,
    input logic                   RESETN,
    input logic                   start,
    input logic                   accept,
    input logic                   idle,
    input logic [OUT_CHARS*8-1:0] result
);

    timeunit 1ns;
    timeprecision 1ps;

    // An accepted start moves the request FSM out of idle at once
    property busy_after_accept;
        @(posedge CLK) disable iff (!RESETN)
            accept |=> !idle;
    endproperty

    // The finished text must not move while the formatter sits idle
    property result_held_when_idle;
        @(posedge CLK) disable iff (!RESETN)
            idle |=> $stable(result);
    endproperty

    // First cycle out of reset finds the FSM idle
    property idle_after_reset;
        @(posedge CLK)
            $rose(RESETN) && !start |-> idle;
    endproperty

    assert property (busy_after_accept)
        else $error("idle was high in the cycle after an accepted start");
    assert property (result_held_when_idle)
        else $error("result changed while the formatter was idle");
    assert property (idle_after_reset)
        else $error("idle was low in the first cycle after reset");

endmodule

// ==== testbench/num_formatter_tb.sv ====
module num_formatter_tb import num_fmt_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIELD_CHARS   = 26;
    localparam int FIELD_BITS    = FIELD_CHARS * 8;
    // Decimal needs about 2,700 cycles, hex only a few
    localparam int IDLE_TIMEOUT  = 5000;
    localparam int RESET_TIMEOUT = 100;

    logic                  CLK;
    logic                  RESETN;
    logic [VALUE_BITS-1:0] value;
    logic                  radix;
    logic [4:0]            hex_digits;
    logic [4:0]            field_width;
    logic                  nosep;
    logic                  start;
    logic [FIELD_BITS-1:0] result;
    logic                  idle;

    int value_errors;
    int timeout_errors;

    // ====================================================================
    // Stimulus and expected-value table with one entry per request
    // ====================================================================

    logic [VALUE_BITS-1:0] row_value  [$];
    logic                  row_radix  [$];
    logic [4:0]            row_digits [$];
    logic [4:0]            row_width  [$];
    logic                  row_nosep  [$];
    // Expected field is right-justified with zero bytes on the left
    logic [FIELD_BITS-1:0] row_text   [$];

    tb_clock_gen u_clock (
        .CLK    (CLK),
        .RESETN (RESETN)
    );

    num_formatter #(
        .OUT_CHARS (FIELD_CHARS)
    ) DUT (
        .CLK         (CLK),
        .RESETN      (RESETN),
        .value       (value),
        .radix       (radix),
        .hex_digits  (hex_digits),
        .field_width (field_width),
        .nosep       (nosep),
        .start       (start),
        .result      (result),
        .idle        (idle)
    );

    bind num_formatter num_formatter_assertions #(
        .OUT_CHARS (OUT_CHARS)
    ) u_assertions (
        .CLK    (CLK),
        .RESETN (RESETN),
        .start  (start),
        .accept (accept),
        .idle   (idle),
        .result (result)
    );

    task automatic add_row(input logic [VALUE_BITS-1:0] v, input logic r,
                           input logic [4:0] digits, input logic [4:0] width,
                           input logic ns, input logic [FIELD_BITS-1:0] text);
        row_value.push_back(v);
        row_radix.push_back(r);
        row_digits.push_back(digits);
        row_width.push_back(width);
        row_nosep.push_back(ns);
        row_text.push_back(text);
    endtask

    task automatic fill_table();
        // Hex rows cover the default count, full width, short counts and the cap at 16
        add_row(64'h0000_0000_12ab_cdef, RADIX_HEX, 5'd0,  5'd0,  1'b0, "12ab_cdef");
        add_row(64'h0123_4567_89ab_cdef, RADIX_HEX, 5'd16, 5'd0,  1'b1, "0123456789abcdef");
        add_row(64'hffff_ffff_fff1_2345, RADIX_HEX, 5'd5,  5'd0,  1'b0, "1_2345");
        add_row(64'hdead_beef_0bad_f00d, RADIX_HEX, 5'd16, 5'd10, 1'b0, "dead_beef_0bad_f00d");
        add_row(64'h0000_0000_0000_0001, RADIX_HEX, 5'd31, 5'd0,  1'b0, "0000_0000_0000_0001");
        add_row(64'h0000_0000_0000_abcd, RADIX_HEX, 5'd4,  5'd0,  1'b0, "abcd");
        // Decimal with commas both with and without a space-filled field
        add_row(64'd1234567, RADIX_DEC, 5'd0, 5'd0,  1'b0, "1,234,567");
        add_row(64'd1234567, RADIX_DEC, 5'd0, 5'd12, 1'b0, "   1,234,567");
        add_row(64'hffff_ffff_ffff_ffff, RADIX_DEC, 5'd0, 5'd0, 1'b0,
                "18,446,744,073,709,551,615");
        // Short text right after the full field must leave nothing behind
        add_row(64'h0000_0000_0000_0005, RADIX_HEX, 5'd1, 5'd0, 1'b0, "5");
        add_row(64'd0,       RADIX_DEC, 5'd0, 5'd0,  1'b0, "0");
        add_row(64'd0,       RADIX_DEC, 5'd0, 5'd5,  1'b0, "    0");
        add_row(64'd1000,    RADIX_DEC, 5'd0, 5'd0,  1'b0, "1,000");
        add_row(64'd999,     RADIX_DEC, 5'd0, 5'd4,  1'b0, " 999");
        // Decimal without separators
        add_row(64'd1234567, RADIX_DEC, 5'd0, 5'd0,  1'b1, "1234567");
        add_row(64'd1234567, RADIX_DEC, 5'd0, 5'd12, 1'b1, "     1234567");
    endtask

    // Zero bytes would not show up in a log, so they print as dots
    function automatic logic [FIELD_BITS-1:0] mark_zero_bytes(input logic [FIELD_BITS-1:0] f);
        logic [FIELD_BITS-1:0] shown;
        shown = f;
        for (int i = 0; i < FIELD_CHARS; i++) begin
            if (shown[i*8 +: 8] == 8'h00) begin
                shown[i*8 +: 8] = 8'h2e;
            end
        end
        return shown;
    endfunction

    task automatic compare_field(input int row, input logic [FIELD_BITS-1:0] got,
                                 input logic [FIELD_BITS-1:0] exp_text);
        if (got !== exp_text) begin
            $display("error at %0t: row %0d result \"%s\", expected \"%s\"", $time, row,
                     mark_zero_bytes(got), mark_zero_bytes(exp_text));
            value_errors++;
        end
    endtask

    // An unknown reset level at time zero counts as still asserted
    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (RESETN !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (RESETN !== 1'b1) begin
            $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
            timeout_errors++;
        end
    endtask

    // Outputs are looked at on falling edges, half a cycle after they change
    task automatic wait_for_idle(input int row);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while (!idle && cycles < IDLE_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (!idle) begin
            $display("Row %0d did not return to idle within %0d cycles", row, IDLE_TIMEOUT);
            timeout_errors++;
        end
    endtask

    // A one-cycle start is followed by scrambled request inputs
    task automatic apply_row(input int row);
        @(negedge CLK);
        value       = row_value[row];
        radix       = row_radix[row];
        hex_digits  = row_digits[row];
        field_width = row_width[row];
        nosep       = row_nosep[row];
        start       = 1'b1;
        @(negedge CLK);
        start       = 1'b0;
        value       = ~row_value[row];
        radix       = ~row_radix[row];
        hex_digits  = ~row_digits[row];
        field_width = ~row_width[row];
        nosep       = ~row_nosep[row];
    endtask

    initial begin
        value_errors   = 0;
        timeout_errors = 0;
        value          = '0;
        radix          = RADIX_HEX;
        hex_digits     = 5'd0;
        field_width    = 5'd0;
        nosep          = 1'b0;
        start          = 1'b0;
        fill_table();
        wait_for_reset();
        for (int i = 0; i < row_value.size(); i++) begin
            // A hung request leaves the DUT busy, so the run stops here
            if (timeout_errors != 0) begin
                break;
            end
            apply_row(i);
            wait_for_idle(i);
            if (idle) begin
                compare_field(i, result, row_text[i]);
            end
        end
        $display("value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
verilog/num_fmt_pkg.sv
verilog/bcd_double_dabble.sv
verilog/digit_emitter.sv
verilog/num_formatter.sv
testbench/tb_clock_gen.sv
testbench/num_formatter_assertions.sv
testbench/num_formatter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the num_formatter testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module num_formatter_tb \
    -f files.f \
    -o num_formatter_sim

./obj_dir/num_formatter_sim > "$LOG" 2>&1
cat "$LOG"

# The testbench prints its fail line on any mismatch or timeout
if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi
echo "Simulation finished without failure"
